// ==== hdl/attr_sorter.sv ====
/*
 * Four-input stable sorting network, purely combinational.
 * Tags each value with its input index, outputs ascending order.
 */
`timescale 1ns/1ns
`default_nettype none

module attr_sorter (
    input  rpg_pkg::attr_t [3:0] vals,
    output rpg_pkg::sort_list_t  sorted
);
    import rpg_pkg::*;

    sort_list_t tagged_in;
    sort_list_t layer0;
    sort_list_t layer1;

    // compare-exchange halves
    function automatic tagged_attr_t lower(tagged_attr_t a, tagged_attr_t b);
        return (a > b) ? b : a;
    endfunction

    function automatic tagged_attr_t upper(tagged_attr_t a, tagged_attr_t b);
        return (a > b) ? a : b;
    endfunction

    always_comb begin
        // tag with input position
        for (int i = 0; i < 4; i++) begin
            tagged_in[i].value = vals[i];
            tagged_in[i].idx   = 2'(i);
        end

        // layer 0, pairs (0,2) and (1,3)
        layer0[0] = lower(tagged_in[0], tagged_in[2]);
        layer0[2] = upper(tagged_in[0], tagged_in[2]);
        layer0[1] = lower(tagged_in[1], tagged_in[3]);
        layer0[3] = upper(tagged_in[1], tagged_in[3]);

        // layer 1, pairs (0,1) and (2,3)
        layer1[0] = lower(layer0[0], layer0[1]);
        layer1[1] = upper(layer0[0], layer0[1]);
        layer1[2] = lower(layer0[2], layer0[3]);
        layer1[3] = upper(layer0[2], layer0[3]);

        // layer 2, middle pair only
        sorted[0] = layer1[0];
        sorted[1] = lower(layer1[1], layer1[2]);
        sorted[2] = upper(layer1[1], layer1[2]);
        sorted[3] = layer1[3];
    end

endmodule

`default_nettype wire

// ==== hdl/battle_unit.sv ====
/*
 * Battle action, combinational.
 * Damage both ways, outcome, then reward or penalty with clamping.
 */
`timescale 1ns/1ns
`default_nettype none

module battle_unit (
    input  rpg_pkg::rpg_req_t     req_q,
    output rpg_pkg::unit_result_t result
);
    import rpg_pkg::*;

    player_t  ply;
    monster_t mon;
    attr_t    dmg_to_player;
    attr_t    dmg_to_monster;
    logic     lose;
    logic     win;

    // penalty step, floor at zero
    function automatic attr_t floor_step(attr_t v);
        return (v < attr_t'(BATTLE_STEP)) ? '0 : v - attr_t'(BATTLE_STEP);
    endfunction

    // reward step, ceiling at ATTR_MAX
    function automatic attr_t ceil_step(attr_t v);
        logic [16:0] s;
        s = 17'(v) + 17'(BATTLE_STEP);
        return s[16] ? attr_t'(ATTR_MAX) : s[15:0];
    endfunction

    assign ply = req_q.player;
    assign mon = req_q.monster;

    // ##############################
    // damage and outcome
    // ##############################
    always_comb begin
        dmg_to_player  = (mon.attack > ply.defense) ? mon.attack - ply.defense : '0;
        dmg_to_monster = (ply.attack > mon.defense) ? ply.attack - mon.defense : '0;
        // loss wins over a double knockout
        lose = (ply.hp <= dmg_to_player);
        win  = !lose && (mon.hp <= dmg_to_monster);
    end

    always_comb begin
        result.player = ply;
        result.warn   = no_warn;
        if (ply.hp == '0) begin
            result.warn = hp_warn;
        end else if (lose) begin
            result.player.hp      = '0;
            result.player.exp     = floor_step(ply.exp);
            result.player.attack  = floor_step(ply.attack);
            result.player.defense = floor_step(ply.defense);
            if (ply.exp < attr_t'(BATTLE_STEP) || ply.attack < attr_t'(BATTLE_STEP) ||
                ply.defense < attr_t'(BATTLE_STEP)) begin
                result.warn = sat_warn;
            end
        end else begin
            // tie and win both keep the reduced hp
            result.player.hp = ply.hp - dmg_to_player;
            if (win) begin
                result.player.exp = ceil_step(ply.exp);
                result.player.mp  = ceil_step(ply.mp);
                if (ply.exp > attr_t'(ATTR_MAX - BATTLE_STEP) ||
                    ply.mp > attr_t'(ATTR_MAX - BATTLE_STEP)) begin
                    result.warn = sat_warn;
                end
            end
        end
    end

endmodule

`default_nettype wire

// ==== hdl/level_up_unit.sv ====
/*
 * Level Up action, combinational.
 * Reads the captured request and the sorted attributes, returns the new record.
 */
`timescale 1ns/1ns
`default_nettype none

module level_up_unit (
    input  rpg_pkg::rpg_req_t     req_q,
    input  rpg_pkg::sort_list_t   sorted_q,
    output rpg_pkg::unit_result_t result
);
    import rpg_pkg::*;

    attr_t [3:0]  cur;
    attr_t [3:0]  nxt;
    attr_t        exp_need;
    logic  [17:0] attr_sum;
    logic  [1:0]  rank   [4];
    logic  [11:0] room   [4];
    logic  [16:0] delta  [4];
    logic  [16:0] scaled [4];
    logic  [17:0] total  [4];
    logic  [3:0]  sat;

    // index 0..3 is mp, hp, attack, defense
    assign cur = {req_q.player.defense, req_q.player.attack,
                  req_q.player.hp, req_q.player.mp};

    // ##############################
    // per-attribute delta
    // ##############################
    always_comb begin
        attr_sum = 18'(cur[0]) + 18'(cur[1]) + 18'(cur[2]) + 18'(cur[3]);
        for (int i = 0; i < 4; i++) begin
            // rank = slot holding this index
            rank[i] = 2'd0;
            for (int s = 0; s < 4; s++) begin
                if (sorted_q[s].idx == 2'(i)) begin
                    rank[i] = 2'(s);
                end
            end
            room[i] = 12'((attr_t'(ATTR_MAX) - cur[i]) >> 4);

            case (req_q.training)
                type_a: delta[i] = 17'(attr_sum >> 3);
                type_b: begin
                    // two weakest pulled up to the upper two
                    if (rank[i] == 2'd0) begin
                        delta[i] = 17'(sorted_q[2].value - cur[i]);
                    end else if (rank[i] == 2'd1) begin
                        delta[i] = 17'(sorted_q[3].value - cur[i]);
                    end else begin
                        delta[i] = '0;
                    end
                end
                type_c: begin
                    delta[i] = (cur[i] < attr_t'(TYPE_C_TARGET)) ?
                               17'(attr_t'(TYPE_C_TARGET) - cur[i]) : '0;
                end
                default: begin
                    // type_d, capped bonus on top of the base
                    delta[i] = 17'(TYPE_D_BASE) +
                               ((room[i] > 12'(TYPE_D_CAP)) ? 17'(TYPE_D_CAP) : 17'(room[i]));
                end
            endcase

            // mode scaling by quarters
            case (req_q.mode)
                easy:    scaled[i] = delta[i] - (delta[i] >> 2);
                hard:    scaled[i] = delta[i] + (delta[i] >> 2);
                default: scaled[i] = delta[i];
            endcase

            total[i] = 18'(cur[i]) + 18'(scaled[i]);
            sat[i]   = (total[i] > 18'(ATTR_MAX));
            nxt[i]   = sat[i] ? attr_t'(ATTR_MAX) : total[i][15:0];
        end
    end

    // ##############################
    // exp gate and result
    // ##############################
    always_comb begin
        case (req_q.mode)
            easy:    exp_need = attr_t'(EXP_NEED_EASY);
            normal:  exp_need = attr_t'(EXP_NEED_NORMAL);
            default: exp_need = attr_t'(EXP_NEED_HARD);
        endcase
    end

    always_comb begin
        result.player = req_q.player;
        if (req_q.player.exp < exp_need) begin
            // record stays untouched
            result.warn = exp_warn;
        end else begin
            result.player.mp      = nxt[0];
            result.player.hp      = nxt[1];
            result.player.attack  = nxt[2];
            result.player.defense = nxt[3];
            result.warn           = (|sat) ? sat_warn : no_warn;
        end
    end

endmodule

`default_nettype wire

// ==== hdl/rpg_ctrl.sv ====
/*
 * Request sequencer: idle, sort, calc, done.
 * Fixed three-cycle latency from strobe to out_valid, one request in flight.
 */
`timescale 1ns/1ns
`default_nettype none

module rpg_ctrl (
    input  logic                  clk,
    input  logic                  rst_n,
    input  logic                  req_valid,
    input  rpg_pkg::rpg_req_t     req,
    input  rpg_pkg::unit_result_t lvl_res,
    input  rpg_pkg::unit_result_t bat_res,
    input  rpg_pkg::unit_result_t skl_res,
    output rpg_pkg::rpg_req_t     req_q,
    output rpg_pkg::sort_list_t   sorted_q,
    output logic                  out_valid,
    output rpg_pkg::warn_t        warn_msg,
    output logic                  complete,
    output rpg_pkg::player_t      player_out
);
    import rpg_pkg::*;

    ctrl_state_t  state;
    ctrl_state_t  state_nxt;
    attr_t [3:0]  sort_in;
    sort_list_t   sort_out;
    unit_result_t res_sel;
    unit_result_t res_q;

    // ##############################
    // FSM
    // ##############################
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state <= idle;
        end else begin
            state <= state_nxt;
        end
    end

    // strobes outside idle are dropped
    always_comb begin
        state_nxt = state;
        case (state)
            idle:    state_nxt = req_valid ? sort : idle;
            sort:    state_nxt = calc;
            calc:    state_nxt = done;
            default: state_nxt = idle;
        endcase
    end

    // ##############################
    // sorter feed
    // ##############################
    always_comb begin
        case (req_q.act)
            level_up: begin
                sort_in = {req_q.player.defense, req_q.player.attack,
                           req_q.player.hp, req_q.player.mp};
            end
            use_skill: sort_in = req_q.skill_cost;
            default:   sort_in = '0;
        endcase
    end

    attr_sorter i_sorter (
        .vals   (sort_in),
        .sorted (sort_out)
    );

    // pick the unit that matches the action
    always_comb begin
        case (req_q.act)
            level_up:  res_sel = lvl_res;
            battle:    res_sel = bat_res;
            use_skill: res_sel = skl_res;
            default:   res_sel = '{player: req_q.player, warn: no_warn};
        endcase
    end

    // ##############################
    // datapath registers
    // ##############################
    always_ff @(posedge clk) begin
        if (state == idle && req_valid) begin
            req_q <= req;
        end
        if (state == sort) begin
            sorted_q <= sort_out;
        end
        if (state == calc) begin
            res_q <= res_sel;
        end
        if (state == done) begin
            player_out <= res_q.player;
        end
    end

    // ##############################
    // output strobe
    // ##############################
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            out_valid <= 1'b0;
            warn_msg  <= no_warn;
            complete  <= 1'b0;
        end else if (state == done) begin
            out_valid <= 1'b1;
            warn_msg  <= res_q.warn;
            complete  <= (res_q.warn == no_warn);
        end else begin
            // single-cycle pulse, flags idle otherwise
            out_valid <= 1'b0;
            warn_msg  <= no_warn;
            complete  <= 1'b0;
        end
    end

endmodule

`default_nettype wire

// ==== hdl/rpg_pkg.sv ====
/*
 * Shared types and game constants for the RPG action engine.
 * Imported by every RTL block and by the testbench reference model.
 */
`default_nettype none

package rpg_pkg;

    // ##############################
    // game constants
    // ##############################
    localparam int unsigned ATTR_MAX        = 65535;
    localparam int unsigned EXP_NEED_EASY   = 4095;
    localparam int unsigned EXP_NEED_NORMAL = 16383;
    localparam int unsigned EXP_NEED_HARD   = 32767;
    localparam int unsigned TYPE_C_TARGET   = 16383;
    localparam int unsigned TYPE_D_BASE     = 3000;
    localparam int unsigned TYPE_D_CAP      = 2047;
    localparam int unsigned BATTLE_STEP     = 2048;

    // ##############################
    // scalar and enum types
    // ##############################
    // one attribute or skill cost
    typedef logic [15:0] attr_t;

    typedef enum logic [1:0] {level_up, battle, use_skill} act_t;
    typedef enum logic [1:0] {easy, normal, hard} mode_t;
    typedef enum logic [1:0] {type_a, type_b, type_c, type_d} training_t;

    // codes 1, 6 and 7 unused here
    typedef enum logic [2:0] {
        no_warn  = 3'd0,
        exp_warn = 3'd2,
        hp_warn  = 3'd3,
        mp_warn  = 3'd4,
        sat_warn = 3'd5
    } warn_t;

    typedef enum logic [1:0] {idle, sort, calc, done} ctrl_state_t;

    // ##############################
    // records
    // ##############################
    // mp..defense map to sorter index 0..3
    typedef struct packed {
        attr_t exp;
        attr_t mp;
        attr_t hp;
        attr_t attack;
        attr_t defense;
    } player_t;

    typedef struct packed {
        attr_t attack;
        attr_t defense;
        attr_t hp;
    } monster_t;

    typedef struct packed {
        act_t        act;
        training_t   training;
        mode_t       mode;
        player_t     player;
        monster_t    monster;
        attr_t [3:0] skill_cost;
    } rpg_req_t;

    // value in the upper bits, so ties fall back to the index
    typedef struct packed {
        attr_t      value;
        logic [1:0] idx;
    } tagged_attr_t;

    // slot 0 holds the smallest entry
    typedef tagged_attr_t [3:0] sort_list_t;

    typedef struct packed {
        player_t player;
        warn_t   warn;
    } unit_result_t;

endpackage

`default_nettype wire

// ==== hdl/rpg_top.sv ====
/*
 * Top level of the RPG action engine.
 * Strobe a packed request in, get one out_valid pulse three cycles later.
 */
`timescale 1ns/1ns
`default_nettype none

module rpg_top (
    input  logic              clk,
    input  logic              rst_n,
    input  logic              req_valid,
    input  rpg_pkg::rpg_req_t req,
    output logic              out_valid,
    output rpg_pkg::warn_t    warn_msg,
    output logic              complete,
    output rpg_pkg::player_t  player_out
);
    import rpg_pkg::*;

    // captured request and its sorted list
    rpg_req_t     req_q;
    sort_list_t   sorted_q;
    // one candidate result per action
    unit_result_t lvl_res;
    unit_result_t bat_res;
    unit_result_t skl_res;

    rpg_ctrl i_ctrl (
        .clk        (clk),
        .rst_n      (rst_n),
        .req_valid  (req_valid),
        .req        (req),
        .lvl_res    (lvl_res),
        .bat_res    (bat_res),
        .skl_res    (skl_res),
        .req_q      (req_q),
        .sorted_q   (sorted_q),
        .out_valid  (out_valid),
        .warn_msg   (warn_msg),
        .complete   (complete),
        .player_out (player_out)
    );

    level_up_unit i_level_up (.req_q(req_q), .sorted_q(sorted_q), .result(lvl_res));

    battle_unit i_battle (.req_q(req_q), .result(bat_res));

    skill_unit i_skill (.req_q(req_q), .sorted_q(sorted_q), .result(skl_res));

endmodule

`default_nettype wire

// ==== hdl/skill_unit.sv ====
/*
 * Use Skill action, combinational.
 * Spends mp on as many of the cheapest skills as fit.
 */
`timescale 1ns/1ns
`default_nettype none

module skill_unit (
    input  rpg_pkg::rpg_req_t     req_q,
    input  rpg_pkg::sort_list_t   sorted_q,
    output rpg_pkg::unit_result_t result
);
    import rpg_pkg::*;

    logic [17:0] psum [4];
    attr_t       spend;

    // running cost of the k+1 cheapest skills
    always_comb begin
        psum[0] = 18'(sorted_q[0].value);
        for (int k = 1; k < 4; k++) begin
            psum[k] = psum[k-1] + 18'(sorted_q[k].value);
        end
    end

    always_comb begin
        // sums only grow, last fit is the largest
        spend = '0;
        for (int k = 0; k < 4; k++) begin
            if (psum[k] <= 18'(req_q.player.mp)) begin
                spend = psum[k][15:0];
            end
        end

        result.player = req_q.player;
        if (psum[0] > 18'(req_q.player.mp)) begin
            result.warn = mp_warn;
        end else begin
            result.player.mp = req_q.player.mp - spend;
            result.warn      = no_warn;
        end
    end

endmodule

`default_nettype wire

// ==== run.sh ====
#!/bin/sh
cd "$(dirname "$0")" &&
verilator --binary --timing --assert --timescale 1ns/1ns \
    -f verilog.f --top-module rpg_tb -o rpg_sim &&
./obj_dir/rpg_sim || exit 1

// ==== verification/rpg_ref.svh ====
/*
 * Reference model of the RPG action engine, included inside the testbench module.
 * rpg_expect gives the expected warning, complete flag and record of one request.
 */
`ifndef RPG_REF_SVH
`define RPG_REF_SVH

// game rules as signed ints
localparam int A_MAX    = int'(ATTR_MAX);
localparam int C_TARGET = int'(TYPE_C_TARGET);
localparam int D_BASE   = int'(TYPE_D_BASE);
localparam int D_CAP    = int'(TYPE_D_CAP);
localparam int STEP     = int'(BATTLE_STEP);

// position of entry i in a stable ascending order
function automatic int stable_rank(input int v [4], input int i);
    int r;
    r = 0;
    for (int j = 0; j < 4; j++) begin
        if (v[j] < v[i] || (v[j] == v[i] && j < i)) begin
            r++;
        end
    end
    return r;
endfunction

// value found at sorted slot s
function automatic int value_at_rank(input int v [4], input int s);
    int res;
    res = 0;
    for (int j = 0; j < 4; j++) begin
        if (stable_rank(v, j) == s) begin
            res = v[j];
        end
    end
    return res;
endfunction

// limit to the attribute range, flag any clamp
function automatic attr_t clamp_range(input int v, inout logic hit);
    if (v < 0) begin
        hit = 1'b1;
        return '0;
    end
    if (v > A_MAX) begin
        hit = 1'b1;
        return attr_t'(A_MAX);
    end
    return attr_t'(v);
endfunction

// ##############################
// level up
// ##############################
function automatic void expect_level_up(input rpg_req_t r, output warn_t w,
                                        output player_t p);
    int    x [4];
    attr_t y [4];
    int    need;
    int    sum;
    int    d;
    int    rk;
    int    room;
    logic  hit;
    p    = r.player;
    x[0] = int'(r.player.mp);
    x[1] = int'(r.player.hp);
    x[2] = int'(r.player.attack);
    x[3] = int'(r.player.defense);
    case (r.mode)
        easy:    need = int'(EXP_NEED_EASY);
        normal:  need = int'(EXP_NEED_NORMAL);
        default: need = int'(EXP_NEED_HARD);
    endcase
    if (int'(r.player.exp) < need) begin
        w = exp_warn;
        return;
    end
    sum = x[0] + x[1] + x[2] + x[3];
    hit = 1'b0;
    for (int i = 0; i < 4; i++) begin
        rk   = stable_rank(x, i);
        room = (A_MAX - x[i]) / 16;
        case (r.training)
            type_a: d = sum / 8;
            // two weakest catch up with the upper two
            type_b: d = (rk == 0) ? value_at_rank(x, 2) - x[i] :
                        (rk == 1) ? value_at_rank(x, 3) - x[i] : 0;
            type_c: d = (x[i] < C_TARGET) ? C_TARGET - x[i] : 0;
            default: d = D_BASE + ((room < D_CAP) ? room : D_CAP);
        endcase
        if (r.mode == easy) begin
            d = d - d / 4;
        end else if (r.mode == hard) begin
            d = d + d / 4;
        end
        y[i] = clamp_range(x[i] + d, hit);
    end
    p.mp      = y[0];
    p.hp      = y[1];
    p.attack  = y[2];
    p.defense = y[3];
    w = hit ? sat_warn : no_warn;
endfunction

// ##############################
// battle and skill
// ##############################
function automatic void expect_battle(input rpg_req_t r, output warn_t w, output player_t p);
    int   dmg_p;
    int   dmg_m;
    int   hp_left;
    int   mon_left;
    logic hit;
    p   = r.player;
    hit = 1'b0;
    if (r.player.hp == '0) begin
        w = hp_warn;
        return;
    end
    dmg_p    = int'(r.monster.attack) - int'(r.player.defense);
    dmg_m    = int'(r.player.attack) - int'(r.monster.defense);
    dmg_p    = (dmg_p < 0) ? 0 : dmg_p;
    dmg_m    = (dmg_m < 0) ? 0 : dmg_m;
    hp_left  = int'(r.player.hp) - dmg_p;
    mon_left = int'(r.monster.hp) - dmg_m;
    if (hp_left <= 0) begin
        // loss
        p.hp      = '0;
        p.exp     = clamp_range(int'(r.player.exp) - STEP, hit);
        p.attack  = clamp_range(int'(r.player.attack) - STEP, hit);
        p.defense = clamp_range(int'(r.player.defense) - STEP, hit);
    end else if (mon_left <= 0) begin
        // win
        p.hp  = attr_t'(hp_left);
        p.exp = clamp_range(int'(r.player.exp) + STEP, hit);
        p.mp  = clamp_range(int'(r.player.mp) + STEP, hit);
    end else begin
        p.hp = attr_t'(hp_left);
    end
    w = hit ? sat_warn : no_warn;
endfunction

function automatic void expect_skill(input rpg_req_t r, output warn_t w, output player_t p);
    int c [4];
    int sum;
    int spend;
    p = r.player;
    for (int k = 0; k < 4; k++) begin
        c[k] = int'(r.skill_cost[k]);
    end
    // cheapest first, keep the last total that still fits
    sum   = 0;
    spend = -1;
    for (int s = 0; s < 4; s++) begin
        sum += value_at_rank(c, s);
        if (sum <= int'(r.player.mp)) begin
            spend = sum;
        end
    end
    if (spend < 0) begin
        w = mp_warn;
    end else begin
        p.mp = attr_t'(int'(r.player.mp) - spend);
        w    = no_warn;
    end
endfunction

function automatic void rpg_expect(input rpg_req_t r, output warn_t w, output logic c,
                                   output player_t p);
    case (r.act)
        level_up: expect_level_up(r, w, p);
        battle:   expect_battle(r, w, p);
        default:  expect_skill(r, w, p);
    endcase
    c = (w == no_warn);
endfunction

`endif

// ==== verification/rpg_tb.sv ====
/*
 * Testbench for rpg_top with directed and random requests sent one at a time.
 * Each response is checked against rpg_expect from rpg_ref.svh.
 */
`timescale 1ns/1ns
`default_nettype none

module rpg_tb;
    import rpg_pkg::*;

    localparam int NUM_REQ        = 400;
    localparam int LATENCY        = 3;
    localparam int TIMEOUT_CYCLES = NUM_REQ * 6 + 100;

    logic     clk;
    logic     rst_n;
    logic     req_valid;
    rpg_req_t req;
    logic     out_valid;
    warn_t    warn_msg;
    logic     complete;
    player_t  player_out;

    int       seed;
    int       cycle_cnt    = 0;
    // strobes sent by the driver and responses seen by the checker
    int       n_strobes    = 0;
    int       n_done       = 0;
    int       strobes_seen = 0;
    int       edges_since  = 0;
    warn_t    want_warn;
    logic     want_complete;
    player_t  want_player;

    `include "rpg_ref.svh"

    rpg_top i_dut (
        .clk        (clk),
        .rst_n      (rst_n),
        .req_valid  (req_valid),
        .req        (req),
        .out_valid  (out_valid),
        .warn_msg   (warn_msg),
        .complete   (complete),
        .player_out (player_out)
    );

    initial begin
        clk = 1'b0;
        forever begin
            #4 clk = ~clk;
        end
    end

    task automatic fail_now(input string what);
        $display("%s", what);
        $display("TESTBENCH FAILED");
        $fatal(1);
    endtask

    task automatic check_value(input string name, input logic [79:0] want,
                               input logic [79:0] got);
        assert (got === want) else begin
            fail_now($sformatf("MISMATCH at %0t ns: %s expected %0h, got %0h",
                               $time, name, want, got));
        end
    endtask

    // ##############################
    // stimulus helpers
    // ##############################
    function automatic player_t make_player(input int e, input int m, input int h,
                                            input int a, input int d);
        player_t p;
        p.exp     = attr_t'(e);
        p.mp      = attr_t'(m);
        p.hp      = attr_t'(h);
        p.attack  = attr_t'(a);
        p.defense = attr_t'(d);
        return p;
    endfunction

    function automatic monster_t make_monster(input int a, input int d, input int h);
        monster_t mon;
        mon.attack  = attr_t'(a);
        mon.defense = attr_t'(d);
        mon.hp      = attr_t'(h);
        return mon;
    endfunction

    function automatic rpg_req_t make_req(input act_t a, input training_t t, input mode_t m,
                                          input player_t p, input monster_t mon,
                                          input attr_t [3:0] costs);
        rpg_req_t r;
        r.act        = a;
        r.training   = t;
        r.mode       = m;
        r.player     = p;
        r.monster    = mon;
        r.skill_cost = costs;
        return r;
    endfunction

    // small, near the top, or anywhere
    function automatic attr_t rand_attr();
        int unsigned v;
        v = $unsigned($random(seed));
        case (v % 4)
            0:       return attr_t'(v[31:20]);
            1:       return attr_t'(16'hffff - 16'(v[31:22]));
            default: return attr_t'(v[31:16]);
        endcase
    endfunction

    function automatic rpg_req_t random_req();
        rpg_req_t r;
        r.act      = act_t'($unsigned($random(seed)) % 3);
        r.training = training_t'($unsigned($random(seed)) % 4);
        r.mode     = mode_t'($unsigned($random(seed)) % 3);
        r.player   = make_player(rand_attr(), rand_attr(), rand_attr(), rand_attr(),
                                 rand_attr());
        r.monster  = make_monster(rand_attr(), rand_attr(), rand_attr());
        for (int k = 0; k < 4; k++) begin
            r.skill_cost[k] = rand_attr();
        end
        return r;
    endfunction

    // starts on a rising edge and returns on the edge after the response
    task automatic send_req(input rpg_req_t r, input logic with_busy);
        rpg_expect(r, want_warn, want_complete, want_player);
        req       <= r;
        req_valid <= 1'b1;
        @(posedge clk);
        // DUT captures on this edge
        n_strobes++;
        if (with_busy) begin
            // repeated strobe in sort must be dropped
            req <= ~r;
            @(posedge clk);
        end
        req_valid <= 1'b0;
        while (n_done != n_strobes) begin
            @(posedge clk);
        end
    endtask

    // ##############################
    // checker and timeout
    // ##############################
    always @(negedge clk) begin
        if (rst_n) begin
            if (n_strobes != strobes_seen) begin
                strobes_seen = n_strobes;
                edges_since  = 0;
            end
            if (n_done != n_strobes && edges_since == LATENCY) begin
                assert (out_valid === 1'b1) else begin
                    fail_now("out_valid did not rise 3 cycles after the request strobe");
                end
                check_value("warn_msg", 80'(want_warn), 80'(warn_msg));
                check_value("complete", 80'(want_complete), 80'(complete));
                check_value("player_out", want_player, player_out);
                n_done++;
            end else begin
                assert (out_valid === 1'b0) else begin
                    fail_now("out_valid pulsed with no response due");
                end
                // flags idle outside the pulse
                check_value("warn_msg", 80'(no_warn), 80'(warn_msg));
                check_value("complete", 80'(1'b0), 80'(complete));
            end
            edges_since++;
        end
    end

    always @(posedge clk) begin
        cycle_cnt <= cycle_cnt + 1;
        if (cycle_cnt >= TIMEOUT_CYCLES) begin
            fail_now("timeout: the run exceeded its cycle limit");
        end
    end

    // ##############################
    // test sequence
    // ##############################
    initial begin
        int need;
        seed      = 92543;
        rst_n     = 1'b0;
        req_valid = 1'b0;
        req       = '0;
        repeat (16) @(posedge clk);
        rst_n <= 1'b1;
        @(posedge clk);
        assert (out_valid === 1'b0 && complete === 1'b0 && warn_msg === no_warn) else begin
            fail_now("outputs not idle after reset");
        end

        // first request carries a strobe while busy
        send_req(make_req(level_up, type_b, normal, make_player(20000, 2000, 2000, 2000, 5000),
                          '0, '0), 1'b1);

        // each training type and mode over mixed, equal and near-top records
        for (int t = 0; t < 4; t++) begin
            for (int m = 0; m < 3; m++) begin
                send_req(make_req(level_up, training_t'(t), mode_t'(m),
                                  make_player(40000, 1000, 3000, 3000, 500), '0, '0), 1'b0);
                send_req(make_req(level_up, training_t'(t), mode_t'(m),
                                  make_player(40000, 2000, 2000, 2000, 5000), '0, '0), 1'b0);
                send_req(make_req(level_up, training_t'(t), mode_t'(m),
                                  make_player(40000, 65000, 64000, 65535, 60000), '0, '0),
                         1'b0);
            end
        end

        // exp just below and at each need
        for (int m = 0; m < 3; m++) begin
            need = (m == 0) ? int'(EXP_NEED_EASY) :
                   (m == 1) ? int'(EXP_NEED_NORMAL) : int'(EXP_NEED_HARD);
            send_req(make_req(level_up, type_a, mode_t'(m),
                              make_player(need - 1, 100, 200, 300, 400), '0, '0), 1'b0);
            send_req(make_req(level_up, type_d, mode_t'(m),
                              make_player(need, 100, 200, 300, 400), '0, '0), 1'b0);
        end

        // battle win, win at the ceiling, two losses, tie, double knockout and dead player
        send_req(make_req(battle, type_a, easy, make_player(10000, 500, 5000, 3000, 1000),
                          make_monster(500, 100, 1000), '0), 1'b0);
        send_req(make_req(battle, type_a, easy, make_player(64000, 65000, 5000, 3000, 1000),
                          make_monster(500, 100, 1000), '0), 1'b0);
        send_req(make_req(battle, type_a, easy, make_player(1000, 500, 100, 1500, 10),
                          make_monster(5000, 0, 60000), '0), 1'b0);
        send_req(make_req(battle, type_a, easy, make_player(10000, 500, 100, 9000, 3000),
                          make_monster(5000, 0, 60000), '0), 1'b0);
        send_req(make_req(battle, type_a, easy, make_player(10000, 500, 5000, 3000, 1000),
                          make_monster(2000, 100, 60000), '0), 1'b0);
        send_req(make_req(battle, type_a, easy, make_player(10000, 500, 100, 3000, 0),
                          make_monster(2000, 0, 10), '0), 1'b0);
        send_req(make_req(battle, type_a, easy, make_player(10000, 500, 0, 3000, 1000),
                          make_monster(500, 100, 1000), '0), 1'b0);

        // skill sets where four, three, two, one or none fit
        send_req(make_req(use_skill, type_a, easy, make_player(0, 100, 1000, 0, 0), '0,
                          {16'd40, 16'd10, 16'd30, 16'd20}), 1'b0);
        send_req(make_req(use_skill, type_a, easy, make_player(0, 60, 1000, 0, 0), '0,
                          {16'd40, 16'd10, 16'd30, 16'd20}), 1'b0);
        send_req(make_req(use_skill, type_a, easy, make_player(0, 35, 1000, 0, 0), '0,
                          {16'd40, 16'd10, 16'd30, 16'd20}), 1'b0);
        send_req(make_req(use_skill, type_a, easy, make_player(0, 15, 1000, 0, 0), '0,
                          {16'd40, 16'd10, 16'd30, 16'd20}), 1'b0);
        send_req(make_req(use_skill, type_a, easy, make_player(0, 5, 1000, 0, 0), '0,
                          {16'd40, 16'd10, 16'd30, 16'd20}), 1'b0);

        // random mix for the rest
        while (n_strobes < NUM_REQ) begin
            send_req(random_req(), 1'b0);
        end

        // room for a stray pulse to show up
        repeat (6) @(posedge clk);
        $display("TESTBENCH PASSED");
        $finish;
    end

endmodule

`default_nettype wire

// ==== verilog.f ====
+incdir+verification
hdl/rpg_pkg.sv
hdl/attr_sorter.sv
hdl/level_up_unit.sv
hdl/battle_unit.sv
hdl/skill_unit.sv
hdl/rpg_ctrl.sv
hdl/rpg_top.sv
verification/rpg_tb.sv
